//--- verilog/tcdm_pkg.sv
// Shared widths, types and engine states for the TCDM slice.
// A single bank of BANK_WORDS words is assumed. Address bits above the
// bank index are ignored by the bank, so addresses alias.

package tcdm_pkg;

  // data word and byte addressing.
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned ADDR_W     = 16;
  localparam int unsigned BE_W       = DATA_W / 8;

  // bank geometry; the index starts above the byte offset.
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned IDX_W      = $clog2(BANK_WORDS);
  localparam int unsigned IDX_LSB    = $clog2(BE_W);

  // stream engine word count.
  localparam int unsigned LEN_W      = 8;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [BE_W-1:0]   be_t;
  typedef logic [IDX_W-1:0]  idx_t;
  typedef logic [LEN_W-1:0]  len_t;

  // stream engine FSM.
  // issue sends reads, drain waits for the last response,
  // done is a single cycle that pulses done_o.
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ISSUE = 2'd1,
    DRAIN = 2'd2,
    DONE  = 2'd3
  } sum_state_e;

endpackage

//--- verilog/core_mux_static.sv
// Static two-way TCDM multiplexer, purely combinational.
// Both initiators must be used strictly in alternation: sel_i is a level,
// there is no arbitration, and responses follow sel_i in the response cycle.
`timescale 1ns/1ps

module core_mux_static import tcdm_pkg::*; (
  input  logic  sel_i,

  // port 0, the host.
  input  logic  in0_req_i,
  input  addr_t in0_add_i,
  input  logic  in0_wen_i,
  input  data_t in0_data_i,
  input  be_t   in0_be_i,
  output logic  in0_gnt_o,
  output logic  in0_r_valid_o,
  output data_t in0_r_data_o,

  // port 1, the stream engine.
  input  logic  in1_req_i,
  input  addr_t in1_add_i,
  input  logic  in1_wen_i,
  input  data_t in1_data_i,
  input  be_t   in1_be_i,
  output logic  in1_gnt_o,
  output logic  in1_r_valid_o,
  output data_t in1_r_data_o,

  // bank side.
  output logic  out_req_o,
  output addr_t out_add_o,
  output logic  out_wen_o,
  output data_t out_data_o,
  output be_t   out_be_o,
  input  logic  out_gnt_i,
  input  logic  out_r_valid_i,
  input  data_t out_r_data_i
);

  // request fields come from the selected port only.
  assign out_req_o  = sel_i ? in1_req_i  : in0_req_i;
  assign out_add_o  = sel_i ? in1_add_i  : in0_add_i;
  assign out_wen_o  = sel_i ? in1_wen_i  : in0_wen_i;
  assign out_data_o = sel_i ? in1_data_i : in0_data_i;
  assign out_be_o   = sel_i ? in1_be_i   : in0_be_i;

  // the unselected port sees grant held low.
  // this is the only back-pressure an initiator gets.
  assign in0_gnt_o = ~sel_i & out_gnt_i;
  assign in1_gnt_o =  sel_i & out_gnt_i;

  // response-valid is steered by sel_i in the cycle it returns,
  // not by the select of the request cycle.
  assign in0_r_valid_o = ~sel_i & out_r_valid_i;
  assign in1_r_valid_o =  sel_i & out_r_valid_i;

  // read data goes to both ports, qualified by r_valid.
  assign in0_r_data_o = out_r_data_i;
  assign in1_r_data_o = out_r_data_i;

endmodule

//--- verilog/tcdm_bank.sv
// Single-port word memory with byte-enabled writes.
// Every request is granted; reads return one cycle later.
// Only address bits IDX_LSB and up to the bank size are decoded.
`timescale 1ns/1ps

module tcdm_bank import tcdm_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  req_i,
  input  addr_t add_i,
  input  logic  wen_i,
  input  data_t data_i,
  input  be_t   be_i,
  output logic  gnt_o,
  output logic  r_valid_o,
  output data_t r_data_o
);

  data_t mem_q [BANK_WORDS];
  idx_t  idx;
  logic  rd_acc;
  logic  wr_acc;
  logic  r_valid_q;
  data_t r_data_q;

  // the bank never stalls.
  assign gnt_o = req_i;

  // word index, upper address bits alias.
  assign idx = add_i[IDX_LSB +: IDX_W];

  // wen high is a read, low is a write.
  assign rd_acc = req_i & gnt_o & wen_i;
  assign wr_acc = req_i & gnt_o & ~wen_i;

  // byte lanes are written only where be_i is set.
  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[idx][8*b +: 8] <= data_i[8*b +: 8];
        end
      end
    end
  end

  // read word is captured with the request.
  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      r_data_q <= mem_q[idx];
    end
  end

  // response-valid, one cycle after the accepted read.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_acc;
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;

  // a granted read seen at the port is answered on the next cycle.
  a_rvalid_follows_read: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (req_i && gnt_o && wen_i) |=> r_valid_o
  );

  // a response at the port always has a granted read one cycle before it.
  a_rvalid_only_after_read: assert property (
    @(posedge clk_i) disable iff (reset_i)
    r_valid_o |-> $past(req_i && gnt_o && wen_i)
  );

  // an initiator must not issue an empty write.
  a_write_has_be: assert property (
    @(posedge clk_i) disable iff (reset_i)
    wr_acc |-> (be_i != '0)
  );

endmodule

//--- verilog/stream_sum.sv
// Streaming sum engine: reads len_i words from base_i and adds them.
// The base is forced to word alignment. Responses are counted only while
// busy, so the select must hold through the cycle after every grant.
// sum_o wraps modulo 2^32 and holds from done_o until the next start.
`timescale 1ns/1ps

module stream_sum import tcdm_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  start_i,
  input  addr_t base_i,
  input  len_t  len_i,
  output logic  busy_o,
  output logic  done_o,
  output data_t sum_o,

  // TCDM initiator port.
  output logic  req_o,
  output addr_t add_o,
  output logic  wen_o,
  output data_t data_o,
  output be_t   be_o,
  input  logic  gnt_i,
  input  logic  r_valid_i,
  input  data_t r_data_i
);

  sum_state_e state_q;
  sum_state_e state_d;
  addr_t      addr_q;
  len_t       len_q;
  len_t       issue_cnt_q;
  len_t       resp_cnt_q;
  len_t       resp_cnt_d;
  data_t      sum_q;
  logic       issue_acc;
  logic       resp_acc;
  logic       last_issue;

  // a request is taken on each grant while issuing.
  assign issue_acc  = req_o & gnt_i;
  assign last_issue = issue_acc && ((issue_cnt_q + len_t'(1)) == len_q);

  // responses count only while a stream is in flight.
  assign resp_acc   = r_valid_i && ((state_q == ISSUE) || (state_q == DRAIN));
  assign resp_cnt_d = resp_acc ? (resp_cnt_q + len_t'(1)) : resp_cnt_q;

  // next state.
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // a zero-length stream finishes at once.
        if (start_i) begin
          state_d = (len_i == '0) ? DONE : ISSUE;
        end
      end
      ISSUE: begin
        if (last_issue) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        if (resp_cnt_d == len_q) begin
          state_d = DONE;
        end
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= IDLE;
      addr_q      <= '0;
      len_q       <= '0;
      issue_cnt_q <= '0;
      resp_cnt_q  <= '0;
      sum_q       <= '0;
    end else begin
      state_q <= state_d;
      // start is ignored unless idle.
      if ((state_q == IDLE) && start_i) begin
        addr_q      <= {base_i[ADDR_W-1:IDX_LSB], {IDX_LSB{1'b0}}};
        len_q       <= len_i;
        issue_cnt_q <= '0;
        resp_cnt_q  <= '0;
        sum_q       <= '0;
      end else begin
        // address moves only on a grant, so a stall holds it.
        if (issue_acc) begin
          addr_q      <= addr_q + addr_t'(BE_W);
          issue_cnt_q <= issue_cnt_q + len_t'(1);
        end
        if (resp_acc) begin
          sum_q <= sum_q + r_data_i;
        end
        resp_cnt_q <= resp_cnt_d;
      end
    end
  end

  // full-word reads only.
  assign req_o  = (state_q == ISSUE);
  assign add_o  = addr_q;
  assign wen_o  = 1'b1;
  assign data_o = '0;
  assign be_o   = '1;

  assign busy_o = (state_q != IDLE);
  assign done_o = (state_q == DONE);
  assign sum_o  = sum_q;

  // the engine stays off the bus between streams.
  a_no_req_idle: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (state_q == IDLE) |=> (!req_o || $past(start_i))
  );

  // no response arrives beyond the words requested.
  a_resp_bounded: assert property (
    @(posedge clk_i) disable iff (reset_i)
    busy_o |-> (resp_cnt_q <= issue_cnt_q) && (resp_cnt_q <= len_q)
  );

endmodule

//--- verilog/tcdm_subsys.sv
// TCDM slice top: host and stream engine share one bank through a
// static multiplexer. sel_i low selects the host, high the engine.
// Software must keep sel_i stable from each grant through its response.
`timescale 1ns/1ps

module tcdm_subsys import tcdm_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  sel_i,

  // host TCDM port.
  input  logic  host_req_i,
  input  addr_t host_add_i,
  input  logic  host_wen_i,
  input  data_t host_data_i,
  input  be_t   host_be_i,
  output logic  host_gnt_o,
  output logic  host_r_valid_o,
  output data_t host_r_data_o,

  // stream engine control.
  input  logic  start_i,
  input  addr_t base_i,
  input  len_t  len_i,
  output logic  busy_o,
  output logic  done_o,
  output data_t sum_o
);

  // engine initiator port.
  logic  eng_req;
  addr_t eng_add;
  logic  eng_wen;
  data_t eng_data;
  be_t   eng_be;
  logic  eng_gnt;
  logic  eng_r_valid;
  data_t eng_r_data;

  // bank target port.
  logic  bank_req;
  addr_t bank_add;
  logic  bank_wen;
  data_t bank_data;
  be_t   bank_be;
  logic  bank_gnt;
  logic  bank_r_valid;
  data_t bank_r_data;

  stream_sum i_stream_sum (
    .clk_i     ( clk_i       ),
    .reset_i   ( reset_i     ),
    .start_i   ( start_i     ),
    .base_i    ( base_i      ),
    .len_i     ( len_i       ),
    .busy_o    ( busy_o      ),
    .done_o    ( done_o      ),
    .sum_o     ( sum_o       ),
    .req_o     ( eng_req     ),
    .add_o     ( eng_add     ),
    .wen_o     ( eng_wen     ),
    .data_o    ( eng_data    ),
    .be_o      ( eng_be      ),
    .gnt_i     ( eng_gnt     ),
    .r_valid_i ( eng_r_valid ),
    .r_data_i  ( eng_r_data  )
  );

  // port 0 is the host, port 1 the engine.
  core_mux_static i_mux (
    .sel_i         ( sel_i          ),
    .in0_req_i     ( host_req_i     ),
    .in0_add_i     ( host_add_i     ),
    .in0_wen_i     ( host_wen_i     ),
    .in0_data_i    ( host_data_i    ),
    .in0_be_i      ( host_be_i      ),
    .in0_gnt_o     ( host_gnt_o     ),
    .in0_r_valid_o ( host_r_valid_o ),
    .in0_r_data_o  ( host_r_data_o  ),
    .in1_req_i     ( eng_req        ),
    .in1_add_i     ( eng_add        ),
    .in1_wen_i     ( eng_wen        ),
    .in1_data_i    ( eng_data       ),
    .in1_be_i      ( eng_be         ),
    .in1_gnt_o     ( eng_gnt        ),
    .in1_r_valid_o ( eng_r_valid    ),
    .in1_r_data_o  ( eng_r_data     ),
    .out_req_o     ( bank_req       ),
    .out_add_o     ( bank_add       ),
    .out_wen_o     ( bank_wen       ),
    .out_data_o    ( bank_data      ),
    .out_be_o      ( bank_be        ),
    .out_gnt_i     ( bank_gnt       ),
    .out_r_valid_i ( bank_r_valid   ),
    .out_r_data_i  ( bank_r_data    )
  );

  tcdm_bank i_bank (
    .clk_i     ( clk_i        ),
    .reset_i   ( reset_i      ),
    .req_i     ( bank_req     ),
    .add_i     ( bank_add     ),
    .wen_i     ( bank_wen     ),
    .data_i    ( bank_data    ),
    .be_i      ( bank_be      ),
    .gnt_o     ( bank_gnt     ),
    .r_valid_o ( bank_r_valid ),
    .r_data_o  ( bank_r_data  )
  );

endmodule

//--- tb/tb_clock_gen.sv
// Free-running testbench clock.
// Starts low, so the first rising edge comes after half a period.
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS = 100
) (
  output logic clk_o
);

  // half period high, half period low.
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

//--- tb/tb_tcdm_subsys.sv
// Testbench for the TCDM slice, run from the project root.
// Operations come from tb/tcdm_trace.txt. The trace's expected values are
// cross-checked against a shadow memory. Streams assume written words only.
`timescale 1ns/1ps

module tb_tcdm_subsys import tcdm_pkg::*; ();

  logic  clk_i;
  logic  reset_i;
  logic  sel_i;
  logic  host_req_i;
  addr_t host_add_i;
  logic  host_wen_i;
  data_t host_data_i;
  be_t   host_be_i;
  logic  host_gnt_o;
  logic  host_r_valid_o;
  data_t host_r_data_o;
  logic  start_i;
  addr_t base_i;
  len_t  len_i;
  logic  busy_o;
  logic  done_o;
  data_t sum_o;

  // one entry per trace operation.
  byte    op_q[$];
  data_t  f1_q[$];
  data_t  f2_q[$];
  data_t  f3_q[$];
  data_t  shadow [BANK_WORDS];
  len_t   max_len;
  bit     trace_loaded;
  integer seed;
  int     errors;
  int     checks;

  tb_clock_gen #(.PERIOD_NS(100)) i_clk_gen (.clk_o(clk_i));

  tcdm_subsys i_dut (.*);

  task automatic check_value(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // bank word index is byte address bits 9 down to 2.
  function automatic idx_t word_index(input addr_t addr);
    return addr[9:2];
  endfunction

  task automatic load_trace();
    int    fd;
    int    code;
    string line;
    byte   c;
    data_t a;
    data_t b;
    data_t d;
    fd = $fopen("tb/tcdm_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the trace file tb/tcdm_trace.txt");
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0 || line.len() == 0) continue;
      c = line.getc(0);
      // comments and blank lines are skipped.
      if (c != "W" && c != "R" && c != "S" && c != "T") continue;
      a = '0;
      b = '0;
      d = '0;
      code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, d);
      op_q.push_back(c);
      f1_q.push_back(a);
      f2_q.push_back(b);
      f3_q.push_back(d);
      if ((c == "S" || c == "T") && (b[LEN_W-1:0] > max_len)) max_len = b[LEN_W-1:0];
    end
    $fclose(fd);
  endtask

  task automatic host_write(input addr_t addr, input data_t data, input be_t be);
    idx_t i;
    i = word_index(addr);
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) shadow[i][8*b +: 8] = data[8*b +: 8];
    end
    @(posedge clk_i);
    sel_i       <= 1'b0;
    host_req_i  <= 1'b1;
    host_add_i  <= addr;
    host_wen_i  <= 1'b0;
    host_data_i <= data;
    host_be_i   <= be;
    @(negedge clk_i);
    check_value("host_gnt_o", data_t'(host_gnt_o), 32'h1);
    @(posedge clk_i);
    host_req_i <= 1'b0;
  endtask

  task automatic host_read(input addr_t addr, input data_t exp);
    check_value("shadow word", shadow[word_index(addr)], exp);
    @(posedge clk_i);
    sel_i      <= 1'b0;
    host_req_i <= 1'b1;
    host_add_i <= addr;
    host_wen_i <= 1'b1;
    host_be_i  <= '1;
    @(negedge clk_i);
    // grant in the request cycle, response in the next one only.
    check_value("host_gnt_o", data_t'(host_gnt_o), 32'h1);
    check_value("host_r_valid_o", data_t'(host_r_valid_o), 32'h0);
    @(posedge clk_i);
    host_req_i <= 1'b0;
    @(negedge clk_i);
    check_value("host_r_valid_o", data_t'(host_r_valid_o), 32'h1);
    check_value("host_r_data_o", host_r_data_o, exp);
    @(negedge clk_i);
    check_value("host_r_valid_o", data_t'(host_r_valid_o), 32'h0);
    check_value("host_gnt_o", data_t'(host_gnt_o), 32'h0);
  endtask

  task automatic run_stream(input addr_t base, input len_t len, input data_t exp, input bit stall);
    data_t sum_ref;
    addr_t a;
    int    k;
    int    rnd;
    bit    done_seen;
    logic  eng_granted;
    logic  sel_next;
    sum_ref = '0;
    a = base;
    for (int n = 0; n < int'(len); n++) begin
      sum_ref = sum_ref + shadow[word_index(a)];
      a = a + addr_t'(4);
    end
    check_value("shadow sum", sum_ref, exp);
    k = 0;
    done_seen = 1'b0;
    eng_granted = 1'b0;
    while (!done_seen) begin
      @(posedge clk_i);
      // a second start with other operands lands while busy.
      start_i <= (k < 2);
      base_i  <= (k == 0) ? base : base + addr_t'(16'h40);
      len_i   <= (k == 0) ? len : len + len_t'(3);
      rnd = $random(seed);
      // the cycle after an engine grant keeps the engine selected.
      sel_next = (stall && !eng_granted) ? rnd[0] : 1'b1;
      sel_i      <= sel_next;
      host_req_i <= sel_next;
      host_wen_i <= 1'b1;
      host_add_i <= base;
      @(negedge clk_i);
      check_value("host_gnt_o", data_t'(host_gnt_o), 32'h0);
      check_value("host_r_valid_o", data_t'(host_r_valid_o), 32'h0);
      check_value("busy_o", data_t'(busy_o), (k == 0) ? 32'h0 : 32'h1);
      eng_granted = i_dut.eng_gnt;
      if (done_o) begin
        done_seen = 1'b1;
        check_value("sum_o", sum_o, exp);
      end
      k++;
    end
    @(posedge clk_i);
    start_i    <= 1'b0;
    sel_i      <= 1'b0;
    host_req_i <= 1'b0;
    @(negedge clk_i);
    // done is a single pulse and the sum holds.
    check_value("done_o", data_t'(done_o), 32'h0);
    check_value("busy_o", data_t'(busy_o), 32'h0);
    check_value("sum_o", sum_o, exp);
  endtask

  initial begin
    data_t a;
    data_t b;
    data_t c;
    reset_i     = 1'b1;
    sel_i       = 1'b0;
    host_req_i  = 1'b0;
    host_add_i  = '0;
    host_wen_i  = 1'b1;
    host_data_i = '0;
    host_be_i   = '0;
    start_i     = 1'b0;
    base_i      = '0;
    len_i       = '0;
    seed        = 77;
    errors      = 0;
    checks      = 0;
    max_len     = '0;
    load_trace();
    trace_loaded = 1'b1;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value("busy_o", data_t'(busy_o), 32'h0);
    check_value("done_o", data_t'(done_o), 32'h0);
    check_value("host_r_valid_o", data_t'(host_r_valid_o), 32'h0);
    check_value("sum_o", sum_o, 32'h0);
    foreach (op_q[n]) begin
      a = f1_q[n];
      b = f2_q[n];
      c = f3_q[n];
      case (op_q[n])
        "W": host_write(a[ADDR_W-1:0], b, c[BE_W-1:0]);
        "R": host_read(a[ADDR_W-1:0], b);
        "S": run_stream(a[ADDR_W-1:0], b[LEN_W-1:0], c, 1'b0);
        "T": run_stream(a[ADDR_W-1:0], b[LEN_W-1:0], c, 1'b1);
        default: ;
      endcase
    end
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // limit grows with the trace length and the longest stream.
  initial begin
    wait (trace_loaded);
    repeat ((op_q.size() + 1) * (int'(max_len) + 64)) @(posedge clk_i);
    $display("watchdog expired before the trace was finished");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- tb/tcdm_trace.txt
# columns: op then hex fields. W addr data be, R addr expected_word
# S base len expected_sum with select high, T the same with random select stalls
W 0000 11111111 f
W 0004 22222222 f
W 0008 33333333 f
W 000c 44444444 f
W 0010 a5a5a5a5 f
W 0014 0000ffff f
W 0018 deadbeef f
W 001c 80000000 f
R 0000 11111111
R 0004 22222222
R 001c 80000000
W 0004 aabbccdd 5
W 0008 12345678 a
W 000c ffffffff 8
R 0004 22bb22dd
R 0008 12335633
R 000c ff444444
R 0400 11111111
S 0000 4 4543ce65
S 0010 2 a5a6a5a4
S 0008 0 00000000
T 0000 8 499832f8
T 0018 2 5eadbeef
W 03fc 01020304 f
T 03fc 3 34ce36f2
R 03fc 01020304
S 0000 8 499832f8

//--- vlog.f
verilog/tcdm_pkg.sv
verilog/core_mux_static.sv
verilog/tcdm_bank.sv
verilog/stream_sum.sv
verilog/tcdm_subsys.sv
tb/tb_clock_gen.sv
tb/tb_tcdm_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Build the TCDM testbench with Verilator and run it from the project root.
rm -f sim.log
verilator --binary --timing --assert --top-module tb_tcdm_subsys -f vlog.f -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  && grep -qx "Simulation PASSED" sim.log \
  || { echo "run_sim.sh: simulation did not pass"; exit 1; }
echo "run_sim.sh: simulation passed"
